//--- dec_pkg.sv
/* decode unit shared definitions
   widths, opcodes, alu operations, load tags and the decode packet */
package dec_pkg;

   // ************************************************************
   // widths
   // ************************************************************
   localparam int XLEN = 32;                        // data width
   localparam int NB_DEPTH = 4;                     // outstanding non-blocking loads

   typedef logic [XLEN-1:0] xlen_t;                 // one data word
   typedef logic [31:1] pc_t;                       // halfword aligned pc
   typedef logic [4:0] reg_addr_t;                  // gpr index
   typedef logic [$clog2(NB_DEPTH)-1:0] nb_tag_t;   // load tag

   // ************************************************************
   // opcodes, rv32i subset
   // ************************************************************
   localparam logic [6:0] OPC_OP = 7'b0110011;      // reg-reg alu
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // reg-imm alu
   localparam logic [6:0] OPC_LUI = 7'b0110111;     // upper immediate
   localparam logic [6:0] OPC_LOAD = 7'b0000011;
   localparam logic [6:0] OPC_STORE = 7'b0100011;

   typedef enum logic [3:0] {
      ADD,
      SUB,
      AND,
      OR,
      XOR,
      SLL,
      SRL,
      SRA,
      SLT,
      SLTU,
      PASS_B                                        // lui, b operand straight through
   } alu_op_e;

   // packet that follows the instruction down x and r
   typedef struct packed {
      logic      valid;
      reg_addr_t rd;                                // destination
      logic      wen;                               // writes gpr at r
      xlen_t     instr;                             // raw word for trace
      pc_t       pc;
   } decode_pkt_t;

endpackage

//--- dec_if.sv
/* decode unit internal interfaces
   gpr read ports and x/r pipe status for the hazard check */
interface gpr_rd_if;
   import dec_pkg::*;

   reg_addr_t raddr0;          // rs1 index
   reg_addr_t raddr1;          // rs2 index
   xlen_t     rdata0;          // combinational read data
   xlen_t     rdata1;

   modport decoder (output raddr0, raddr1, input rdata0, rdata1);
   modport regfile (input raddr0, raddr1, output rdata0, rdata1);
endinterface

interface pipe_stat_if;
   import dec_pkg::*;

   logic      x_valid;         // instruction in x
   reg_addr_t x_rd;
   logic      x_wen;
   logic      r_valid;         // instruction in r
   reg_addr_t r_rd;
   logic      r_wen;

   modport drive (output x_valid, x_rd, x_wen, r_valid, r_rd, r_wen);
   modport read (input x_valid, x_rd, x_wen, r_valid, r_rd, r_wen);
endinterface

//--- dec_ib.sv
/* one-entry instruction buffer, holds the fetched word at d */
module dec_ib (
   input  logic           clk,
   input  logic           arst_n,
   input  logic           ifu_i0_valid,      // fetch offers an instruction
   input  dec_pkg::xlen_t ifu_i0_instr,
   input  dec_pkg::pc_t   ifu_i0_pc,
   input  logic           decode_d,          // d slot consumed this cycle
   output logic           ib_ready,
   output logic           ib_valid,
   output dec_pkg::xlen_t ib_instr,
   output dec_pkg::pc_t   ib_pc
);

   logic accept;                              // fetch handshake

   assign ib_ready = ~ib_valid | decode_d;    // empty or leaving now
   assign accept = ifu_i0_valid & ib_ready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ib_valid <= 1'b0;
      end else if (accept) begin
         ib_valid <= 1'b1;
      end else if (decode_d) begin
         ib_valid <= 1'b0;                    // drained, nothing new
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         ib_instr <= ifu_i0_instr;
         ib_pc <= ifu_i0_pc;
      end
   end

   // the decoder only drains a full buffer
   a_drain_full: assert property (
      @(posedge clk) disable iff (!arst_n)
      decode_d |-> ib_valid
   );

endmodule

//--- dec_decode.sv
/* d-stage decode of rv32i op, op-imm, lui, load and store
   builds the alu and load/store packets and the hazard stall */
module dec_decode (
   input  logic               ib_valid,
   input  dec_pkg::xlen_t     ib_instr,
   input  dec_pkg::pc_t       ib_pc,
   gpr_rd_if.decoder          gpr,
   pipe_stat_if.read          stat,
   input  logic               sb_busy_rs1,     // pending load targets rs1
   input  logic               sb_busy_rs2,
   input  logic               sb_busy_rd,
   input  logic               sb_free,         // a load tag is free
   input  dec_pkg::nb_tag_t   sb_free_tag,
   output logic               decode_d,
   output logic               dec_illegal_d,
   output dec_pkg::alu_op_e   dec_alu_op,
   output dec_pkg::xlen_t     dec_rs1_data,
   output dec_pkg::xlen_t     dec_rs2_data,
   output dec_pkg::xlen_t     dec_immed,
   output logic               dec_use_imm,
   output logic               dec_lsu_load,
   output logic               dec_lsu_store,
   output dec_pkg::nb_tag_t   dec_lsu_tag,
   output dec_pkg::reg_addr_t sb_rs1,
   output dec_pkg::reg_addr_t sb_rs2,
   output dec_pkg::reg_addr_t sb_rd,
   output logic               sb_alloc,
   output dec_pkg::decode_pkt_t dec_pkt
);
   import dec_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   reg_addr_t  rs1, rs2, rd;
   logic       is_op, is_op_imm, is_lui, is_load, is_store, legal;
   logic       use_rs1, use_rs2, use_rd;
   xlen_t      imm_i, imm_s, imm_u;
   logic       x_live, r_live;                 // stage will write the gpr
   logic       rs1_hit, rs2_hit, rd_hit, stall;

   // ************************************************************
   // field extraction
   // ************************************************************
   assign opcode = ib_instr[6:0];
   assign rd = ib_instr[11:7];
   assign funct3 = ib_instr[14:12];
   assign rs1 = ib_instr[19:15];
   assign rs2 = ib_instr[24:20];
   assign funct7 = ib_instr[31:25];

   assign imm_i = {{20{ib_instr[31]}}, ib_instr[31:20]};
   assign imm_s = {{20{ib_instr[31]}}, ib_instr[31:25], ib_instr[11:7]};
   assign imm_u = {ib_instr[31:12], 12'b0};

   assign is_op = (opcode == OPC_OP);
   assign is_op_imm = (opcode == OPC_OP_IMM);
   assign is_lui = (opcode == OPC_LUI);
   assign is_load = (opcode == OPC_LOAD);
   assign is_store = (opcode == OPC_STORE);
   assign legal = is_op | is_op_imm | is_lui | is_load | is_store;

   assign use_rs1 = is_op | is_op_imm | is_load | is_store;
   assign use_rs2 = is_op | is_store;
   assign use_rd = is_op | is_op_imm | is_lui | is_load;   // store has no rd

   always_comb begin
      dec_alu_op = ADD;                        // load/store address add
      if (is_lui) begin
         dec_alu_op = PASS_B;
      end else if (is_op || is_op_imm) begin
         case (funct3)
            3'b000:  dec_alu_op = (is_op && funct7[5]) ? SUB : ADD;
            3'b001:  dec_alu_op = SLL;
            3'b010:  dec_alu_op = SLT;
            3'b011:  dec_alu_op = SLTU;
            3'b100:  dec_alu_op = XOR;
            3'b101:  dec_alu_op = funct7[5] ? SRA : SRL;
            3'b110:  dec_alu_op = OR;
            default: dec_alu_op = AND;
         endcase
      end
   end

   assign dec_immed = is_store ? imm_s : is_lui ? imm_u : is_op ? '0 : imm_i;
   assign dec_use_imm = ~is_op;

   // ************************************************************
   // hazards, no bypass so wait for the gpr write
   // ************************************************************
   assign x_live = stat.x_valid & stat.x_wen;
   assign r_live = stat.r_valid & stat.r_wen;

   assign rs1_hit = use_rs1 & (rs1 != '0) & ((x_live & (stat.x_rd == rs1)) |
                    (r_live & (stat.r_rd == rs1)) | sb_busy_rs1);
   assign rs2_hit = use_rs2 & (rs2 != '0) & ((x_live & (stat.x_rd == rs2)) |
                    (r_live & (stat.r_rd == rs2)) | sb_busy_rs2);
   assign rd_hit = use_rd & (rd != '0) & ((x_live & (stat.x_rd == rd)) |
                   (r_live & (stat.r_rd == rd)) | sb_busy_rd);   // waw
   assign stall = rs1_hit | rs2_hit | rd_hit | (is_load & ~sb_free);

   assign decode_d = ib_valid & legal & ~stall;
   assign dec_illegal_d = ib_valid & ~legal;   // dropped, buffer drains

   assign gpr.raddr0 = rs1;
   assign gpr.raddr1 = rs2;
   assign dec_rs1_data = gpr.rdata0;
   assign dec_rs2_data = gpr.rdata1;

   assign dec_lsu_load = decode_d & is_load;
   assign dec_lsu_store = decode_d & is_store;
   assign dec_lsu_tag = sb_free_tag;           // lowest free tag
   assign sb_rs1 = rs1;
   assign sb_rs2 = rs2;
   assign sb_rd = rd;
   assign sb_alloc = decode_d & is_load;

   // loads write through the nb port, never at r
   assign dec_pkt = '{valid: decode_d,
                      rd:    rd,
                      wen:   decode_d & (is_op | is_op_imm | is_lui) & (rd != '0),
                      instr: ib_instr,
                      pc:    ib_pc};

endmodule

//--- dec_nbload_sb.sv
/* non-blocking load scoreboard, one valid bit and rd per tag */
module dec_nbload_sb (
   input  logic               clk,
   input  logic               arst_n,
   input  dec_pkg::reg_addr_t sb_rs1,
   input  dec_pkg::reg_addr_t sb_rs2,
   input  dec_pkg::reg_addr_t sb_rd,
   input  logic               sb_alloc,       // load decoded this cycle
   input  logic               lsu_nb_valid,   // load data returns
   input  dec_pkg::nb_tag_t   lsu_nb_tag,
   output logic               sb_busy_rs1,
   output logic               sb_busy_rs2,
   output logic               sb_busy_rd,
   output logic               sb_free,
   output dec_pkg::nb_tag_t   sb_free_tag,
   output logic               nb_wen,
   output dec_pkg::reg_addr_t nb_waddr
);
   import dec_pkg::*;

   logic [NB_DEPTH-1:0] tag_valid;             // load outstanding
   reg_addr_t           tag_rd [NB_DEPTH];     // its destination

   always_comb begin
      sb_busy_rs1 = 1'b0;
      sb_busy_rs2 = 1'b0;
      sb_busy_rd = 1'b0;
      sb_free_tag = '0;
      for (int i = 0; i < NB_DEPTH; i++) begin
         sb_busy_rs1 |= tag_valid[i] & (tag_rd[i] == sb_rs1);
         sb_busy_rs2 |= tag_valid[i] & (tag_rd[i] == sb_rs2);
         sb_busy_rd |= tag_valid[i] & (tag_rd[i] == sb_rd);
      end
      for (int i = NB_DEPTH - 1; i >= 0; i--) begin
         if (!tag_valid[i]) sb_free_tag = nb_tag_t'(i);   // lowest wins
      end
   end

   assign sb_free = ~&tag_valid;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         tag_valid <= '0;
      end else begin
         if (lsu_nb_valid) tag_valid[lsu_nb_tag] <= 1'b0;   // freed, error or not
         if (sb_alloc) tag_valid[sb_free_tag] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (sb_alloc) tag_rd[sb_free_tag] <= sb_rd;
   end

   assign nb_wen = lsu_nb_valid;               // error mask at top
   assign nb_waddr = tag_rd[lsu_nb_tag];

   // lsu may only return a tag decode handed out
   a_tag_live: assert property (
      @(posedge clk) disable iff (!arst_n) lsu_nb_valid |-> tag_valid[lsu_nb_tag]
   );

endmodule

//--- dec_gpr.sv
/* 32 x 32 register file, two combinational reads, two writes, x0 zero */
module dec_gpr (
   input  logic               clk,
   input  logic               arst_n,
   gpr_rd_if.regfile          rd,
   input  logic               wen0,           // r-stage result
   input  logic               wen1,           // non-blocking load
   input  dec_pkg::reg_addr_t waddr0,
   input  dec_pkg::reg_addr_t waddr1,
   input  dec_pkg::xlen_t     wd0,
   input  dec_pkg::xlen_t     wd1
);
   import dec_pkg::*;

   xlen_t gpr_q [1:31];                        // x0 has no storage

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 1; i < 32; i++) begin
            gpr_q[i] <= '0;
         end
      end else begin
         if (wen0 && waddr0 != '0) gpr_q[waddr0] <= wd0;
         if (wen1 && waddr1 != '0) gpr_q[waddr1] <= wd1;
      end
   end

   assign rd.rdata0 = (rd.raddr0 == '0) ? '0 : gpr_q[rd.raddr0];
   assign rd.rdata1 = (rd.raddr1 == '0) ? '0 : gpr_q[rd.raddr1];

   // decode waw stall keeps r and load returns apart
   a_no_dual_write: assert property (
      @(posedge clk) disable iff (!arst_n)
      !(wen0 && wen1 && waddr0 == waddr1 && waddr0 != '0)
   );

endmodule

//--- dec_result.sv
/* x and r stage registers, r-stage writeback and the wb trace record */
module dec_result (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 decode_d,
   input  dec_pkg::decode_pkt_t dec_pkt,
   input  dec_pkg::xlen_t       exu_i0_result_x,   // alu result, valid in x
   pipe_stat_if.drive           stat,
   output logic                 wen0,
   output dec_pkg::reg_addr_t   waddr0,
   output dec_pkg::xlen_t       dec_i0_result_r,
   output logic                 trace_valid,
   output dec_pkg::xlen_t       trace_insn,
   output dec_pkg::pc_t         trace_pc
);
   import dec_pkg::*;

   logic        x_valid, r_valid;
   decode_pkt_t x_pkt, r_pkt;
   xlen_t       r_result;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         x_valid <= 1'b0;
         r_valid <= 1'b0;
         trace_valid <= 1'b0;
      end else begin
         x_valid <= dec_pkt.valid;
         r_valid <= x_valid;
         trace_valid <= r_valid;               // wb, one cycle
      end
   end

   always_ff @(posedge clk) begin
      if (decode_d) x_pkt <= dec_pkt;
      if (x_valid) begin
         r_pkt <= x_pkt;
         r_result <= exu_i0_result_x;          // capture at end of x
      end
      if (r_valid) begin
         trace_insn <= r_pkt.instr;
         trace_pc <= r_pkt.pc;
      end
   end

   assign wen0 = r_valid & r_pkt.wen;          // gpr written at edge ending r
   assign waddr0 = r_pkt.rd;
   assign dec_i0_result_r = r_result;

   assign stat.x_valid = x_valid;
   assign stat.x_rd = x_pkt.rd;
   assign stat.x_wen = x_pkt.wen;
   assign stat.r_valid = r_valid;
   assign stat.r_rd = r_pkt.rd;
   assign stat.r_wen = r_pkt.wen;

endmodule

//--- dec_top.sv
/* rv32i decode unit top, buffer, decode, scoreboard, gpr and result pipe */
module dec_top (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             ifu_i0_valid,
   input  dec_pkg::xlen_t   ifu_i0_instr,
   input  dec_pkg::pc_t     ifu_i0_pc,
   input  dec_pkg::xlen_t   exu_i0_result_x,
   input  logic             lsu_nb_valid,
   input  logic             lsu_nb_error,
   input  dec_pkg::nb_tag_t lsu_nb_tag,
   input  dec_pkg::xlen_t   lsu_nb_data,
   output logic             ib_ready,
   output logic             dec_i0_decode_d,
   output logic             dec_illegal_d,
   output dec_pkg::alu_op_e dec_alu_op,
   output dec_pkg::xlen_t   dec_rs1_data,
   output dec_pkg::xlen_t   dec_rs2_data,
   output dec_pkg::xlen_t   dec_immed,
   output logic             dec_use_imm,
   output logic             dec_lsu_load,
   output logic             dec_lsu_store,
   output dec_pkg::nb_tag_t dec_lsu_tag,
   output dec_pkg::xlen_t   dec_i0_result_r,
   output logic             trace_valid,
   output dec_pkg::xlen_t   trace_insn,
   output dec_pkg::pc_t     trace_pc
);
   import dec_pkg::*;

   logic        ib_valid, ib_consume;
   xlen_t       ib_instr;
   pc_t         ib_pc;
   logic        sb_busy_rs1, sb_busy_rs2, sb_busy_rd, sb_free, sb_alloc;
   nb_tag_t     sb_free_tag;
   reg_addr_t   sb_rs1, sb_rs2, sb_rd;
   logic        nb_wen, wen0;
   reg_addr_t   nb_waddr, waddr0;
   decode_pkt_t dec_pkt;

   gpr_rd_if    gpr_rd ();
   pipe_stat_if pipe_stat ();

   assign ib_consume = dec_i0_decode_d | dec_illegal_d;   // illegal also drains

   dec_ib ib_i (
      .clk, .arst_n, .ifu_i0_valid, .ifu_i0_instr, .ifu_i0_pc,
      .decode_d (ib_consume),
      .ib_ready, .ib_valid, .ib_instr, .ib_pc
   );

   dec_decode decode_i (
      .ib_valid, .ib_instr, .ib_pc,
      .gpr      (gpr_rd.decoder),
      .stat     (pipe_stat.read),
      .sb_busy_rs1, .sb_busy_rs2, .sb_busy_rd, .sb_free, .sb_free_tag,
      .decode_d (dec_i0_decode_d),
      .dec_illegal_d, .dec_alu_op, .dec_rs1_data, .dec_rs2_data, .dec_immed,
      .dec_use_imm, .dec_lsu_load, .dec_lsu_store, .dec_lsu_tag,
      .sb_rs1, .sb_rs2, .sb_rd, .sb_alloc, .dec_pkt
   );

   dec_nbload_sb nbload_sb_i (
      .clk, .arst_n, .sb_rs1, .sb_rs2, .sb_rd, .sb_alloc, .lsu_nb_valid, .lsu_nb_tag,
      .sb_busy_rs1, .sb_busy_rs2, .sb_busy_rd, .sb_free, .sb_free_tag,
      .nb_wen, .nb_waddr
   );

   // ************************************************************
   // gpr, port 0 from r, port 1 from load return
   // ************************************************************
   dec_gpr gpr_i (
      .clk, .arst_n,
      .rd     (gpr_rd.regfile),
      .wen0,
      .wen1   (nb_wen & ~lsu_nb_error),       // errored load writes nothing
      .waddr0,
      .waddr1 (nb_waddr),
      .wd0    (dec_i0_result_r),
      .wd1    (lsu_nb_data)
   );

   dec_result result_i (
      .clk, .arst_n,
      .decode_d (dec_i0_decode_d),
      .dec_pkt, .exu_i0_result_x,
      .stat     (pipe_stat.drive),
      .wen0, .waddr0, .dec_i0_result_r, .trace_valid, .trace_insn, .trace_pc
   );

endmodule

//--- tb_dec_checks.svh
/* testbench helpers
   random numbers, reference decode and alu model, compare tasks */
`ifndef TB_DEC_CHECKS_SVH
`define TB_DEC_CHECKS_SVH

int unsigned lcg_state = 30084;                        // fixed seed
int          error_count = 0;

function automatic xlen_t lcg_next();
   lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
   return xlen_t'({lcg_state[15:0], lcg_state[31:16]});   // weak low bits moved up
endfunction

task automatic report_failure(string what);
   error_count++;
   $display("%s", what);
   $display("Finished with errors");
   $fatal(1, "stopped at first error");
endtask

// ************************************************************
// compare tasks, one per result type
// ************************************************************
task automatic check_xlen(string name, xlen_t got, xlen_t exp);
   if (got !== exp) begin
      report_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
   end
endtask

task automatic check_alu_op(string name, alu_op_e got, alu_op_e exp);
   if (got !== exp) begin
      report_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
   end
endtask

task automatic check_tag(string name, nb_tag_t got, nb_tag_t exp);
   if (got !== exp) begin
      report_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
   end
endtask

task automatic check_bit(string name, logic got, logic exp);
   if (got !== exp) begin
      report_failure($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
   end
endtask

// ************************************************************
// reference decode and alu
// ************************************************************
function automatic alu_op_e ref_alu_op(xlen_t insn);
   logic [6:0] opc;
   opc = insn[6:0];
   if (opc == OPC_LUI) return PASS_B;
   if (opc != OPC_OP && opc != OPC_OP_IMM) return ADD;   // address add
   case (insn[14:12])
      3'd0:    return (opc == OPC_OP && insn[30]) ? SUB : ADD;
      3'd1:    return SLL;
      3'd2:    return SLT;
      3'd3:    return SLTU;
      3'd4:    return XOR;
      3'd5:    return insn[30] ? SRA : SRL;
      3'd6:    return OR;
      default: return AND;
   endcase
endfunction

function automatic xlen_t ref_immed(xlen_t insn);
   case (insn[6:0])
      OPC_STORE: return {{20{insn[31]}}, insn[31:25], insn[11:7]};
      OPC_LUI:   return {insn[31:12], 12'h000};
      default:   return {{20{insn[31]}}, insn[31:20]};   // i-type
   endcase
endfunction

function automatic xlen_t alu_model(alu_op_e op, xlen_t a, xlen_t b);
   case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLL:     return a << b[4:0];
      SRL:     return a >> b[4:0];
      SRA:     return xlen_t'($signed(a) >>> b[4:0]);
      SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      SLTU:    return (a < b) ? 32'd1 : 32'd0;
      default: return b;                               // lui
   endcase
endfunction

`endif

//--- tb_dec.sv
/* testbench for the rv32i decode unit
   plays fetch, execute and load unit, checks decode, writeback and trace */
module tb_dec;
   import dec_pkg::*;

   localparam int N_INSTR = 27;                        // issued over all tests
   localparam int CYCLE_LIMIT = 20 * N_INSTR + 200;

   typedef struct {
      xlen_t insn;
      pc_t   pc;
      int    cyc;                                      // decode cycle
      xlen_t res;                                      // modelled alu result
   } slot_t;

   logic    clk, arst_n, ifu_i0_valid, lsu_nb_valid, lsu_nb_error;
   xlen_t   ifu_i0_instr, exu_i0_result_x, lsu_nb_data;
   pc_t     ifu_i0_pc;
   nb_tag_t lsu_nb_tag;
   logic    ib_ready, dec_i0_decode_d, dec_illegal_d, dec_use_imm;
   logic    dec_lsu_load, dec_lsu_store, trace_valid;
   alu_op_e dec_alu_op;
   xlen_t   dec_rs1_data, dec_rs2_data, dec_immed, dec_i0_result_r, trace_insn;
   nb_tag_t dec_lsu_tag;
   pc_t     trace_pc;

   xlen_t     shadow [32];                             // expected gpr
   logic      tag_busy [NB_DEPTH];                     // load outstanding
   reg_addr_t tag_rd [NB_DEPTH];
   slot_t     fetch_q [$];                             // head sits at d
   slot_t     trace_q [$];                             // awaiting wb
   int        decode_cyc [$];
   int        cycle = 0, decode_count = 0, illegal_count = 0;
   xlen_t     x_result = '0, last_rs1;
   pc_t       pc_next = 31'h100;

   `include "tb_dec_checks.svh"

   dec_top dec_top_i (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle++;
      if (cycle > CYCLE_LIMIT) begin
         report_failure($sformatf("timeout, DUT made no progress in %0d cycles", cycle));
      end
   end

   // execute stage, result in the cycle after decode
   always @(posedge clk) begin
      #10;
      exu_i0_result_x = x_result;
   end

   // ************************************************************
   // encoders and bookkeeping
   // ************************************************************
   function automatic xlen_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3, reg_addr_t rd);
      return {f7, rs2, rs1, f3, rd, OPC_OP};
   endfunction

   function automatic xlen_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                   reg_addr_t rd, logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic xlen_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};   // sw
   endfunction

   function automatic xlen_t enc_u(logic [19:0] imm, reg_addr_t rd);
      return {imm, rd, OPC_LUI};
   endfunction

   function automatic nb_tag_t lowest_free_tag();
      for (int i = 0; i < NB_DEPTH; i++) begin
         if (!tag_busy[i]) return nb_tag_t'(i);
      end
      return '0;
   endfunction

   task automatic check_decode(slot_t s);
      logic [6:0] opc;
      reg_addr_t  rd;
      xlen_t      b;
      nb_tag_t    tag;
      opc = s.insn[6:0];
      rd = s.insn[11:7];
      check_alu_op("dec_alu_op", dec_alu_op, ref_alu_op(s.insn));
      check_bit("dec_use_imm", dec_use_imm, opc != OPC_OP);
      if (opc != OPC_OP) check_xlen("dec_immed", dec_immed, ref_immed(s.insn));
      check_bit("dec_lsu_load", dec_lsu_load, opc == OPC_LOAD);
      check_bit("dec_lsu_store", dec_lsu_store, opc == OPC_STORE);
      if (opc != OPC_LUI) check_xlen("dec_rs1_data", dec_rs1_data, shadow[s.insn[19:15]]);
      if (opc == OPC_OP || opc == OPC_STORE) begin
         check_xlen("dec_rs2_data", dec_rs2_data, shadow[s.insn[24:20]]);
      end
      b = (opc == OPC_OP) ? shadow[s.insn[24:20]] : ref_immed(s.insn);
      x_result = alu_model(ref_alu_op(s.insn), shadow[s.insn[19:15]], b);
      if (opc == OPC_LOAD) begin
         tag = lowest_free_tag();
         check_tag("dec_lsu_tag", dec_lsu_tag, tag);
         tag_busy[tag] = 1'b1;
         tag_rd[tag] = rd;
      end else if (opc != OPC_STORE && rd != '0) begin
         shadow[rd] = x_result;                        // stall keeps readers behind the write
      end
      last_rs1 = dec_rs1_data;
      s.cyc = cycle;
      s.res = x_result;
      trace_q.push_back(s);
      decode_cyc.push_back(cycle);
      decode_count++;
   endtask

   always @(negedge clk) begin : monitor
      slot_t s;
      if (arst_n && (dec_i0_decode_d || dec_illegal_d)) begin
         s = fetch_q.pop_front();
         if (dec_illegal_d) begin
            check_bit("dec_i0_decode_d", dec_i0_decode_d, 1'b0);
            illegal_count++;                           // dropped, no trace
         end else begin
            check_decode(s);
         end
      end
      if (trace_valid) begin
         if (trace_q.size() == 0) begin
            report_failure("trace record seen with no instruction in flight");
         end else begin
            s = trace_q.pop_front();
            check_xlen("trace_insn", trace_insn, s.insn);
            check_xlen("trace_pc", {trace_pc, 1'b0}, {s.pc, 1'b0});
            check_xlen("trace latency", cycle - s.cyc, 3);
         end
      end
      foreach (trace_q[i]) begin
         if (trace_q[i].cyc == cycle - 2) begin
            check_xlen("dec_i0_result_r", dec_i0_result_r, trace_q[i].res);   // r stage
         end
      end
   end

   // ************************************************************
   // drivers, each starts and ends 10 units after a rising edge
   // ************************************************************
   task automatic idle(int n);
      repeat (n) begin
         @(posedge clk);
         #10;
      end
   endtask

   task automatic issue(xlen_t insn);
      slot_t s;
      s.insn = insn;
      s.pc = pc_next;
      pc_next += 31'd2;                                // 4 bytes
      ifu_i0_valid = 1'b1;
      ifu_i0_instr = insn;
      ifu_i0_pc = s.pc;
      @(negedge clk);
      while (!ib_ready) @(negedge clk);
      fetch_q.push_back(s);
      @(posedge clk);                                  // accepted here
      #10;
      ifu_i0_valid = 1'b0;
   endtask

   task automatic wait_decodes(int n);
      while (decode_count < n) idle(1);
   endtask

   task automatic load_return(nb_tag_t tag, xlen_t data, logic err);
      lsu_nb_valid = 1'b1;
      lsu_nb_tag = tag;
      lsu_nb_data = data;
      lsu_nb_error = err;
      if (!err && tag_rd[tag] != '0) shadow[tag_rd[tag]] = data;
      tag_busy[tag] = 1'b0;
      idle(1);
      lsu_nb_valid = 1'b0;
   endtask

   // ************************************************************
   // directed tests
   // ************************************************************
   task automatic test_reset_state();
      @(negedge clk);
      check_bit("ib_ready", ib_ready, 1'b1);
      check_bit("dec_i0_decode_d", dec_i0_decode_d, 1'b0);
      check_bit("dec_illegal_d", dec_illegal_d, 1'b0);
      check_bit("trace_valid", trace_valid, 1'b0);
      check_bit("dec_lsu_load", dec_lsu_load, 1'b0);
      check_bit("dec_lsu_store", dec_lsu_store, 1'b0);
      idle(1);
   endtask

   task automatic test_decode_fields();
      int start;
      start = decode_count;
      issue(enc_i(12'hffb, 5'd2, 3'b000, 5'd1, OPC_OP_IMM));   // addi x1, x2, -5
      issue(enc_r(7'h00, 5'd5, 5'd4, 3'b000, 5'd3));           // add
      issue(enc_r(7'h20, 5'd8, 5'd7, 3'b000, 5'd6));           // sub
      issue(enc_i(12'h003, 5'd1, 3'b001, 5'd9, OPC_OP_IMM));   // slli x9, x1, 3
      issue(enc_u(20'habcde, 5'd11));                          // lui
      issue(enc_s(12'h9f0, 5'd9, 5'd12));                      // negative offset
      wait_decodes(start + 6);
   endtask

   task automatic test_writeback();
      xlen_t     r;
      reg_addr_t rd, rs;
      for (int i = 0; i < 3; i++) begin
         r = lcg_next();
         rd = (r[20:16] == '0) ? 5'd17 : r[20:16];
         rs = (rd == 5'd31) ? 5'd1 : rd + 5'd1;
         issue(enc_u(r[31:12], rs));
         r = lcg_next();
         issue(enc_i(r[11:0], rs, {r[13:12], 1'b0}, rd, OPC_OP_IMM));   // add/slt/xor/or
         issue(enc_r(7'h00, 5'd0, rd, 3'b000, 5'd0));                   // reader
      end
      wait_decodes(decode_count + fetch_q.size());
   endtask

   task automatic test_raw();
      int start;
      start = decode_count;
      issue(enc_i(12'h123, 5'd0, 3'b000, 5'd14, OPC_OP_IMM));
      issue(enc_r(7'h00, 5'd14, 5'd14, 3'b000, 5'd15));        // back to back
      wait_decodes(start + 2);
      check_xlen("raw decode distance", decode_cyc[start + 1] - decode_cyc[start], 3);
      check_xlen("dec_rs1_data", last_rs1, 32'h123);
   endtask

   task automatic test_nb_load();
      int      start;
      nb_tag_t t;
      xlen_t   d;
      start = decode_count;
      t = lowest_free_tag();
      d = lcg_next();
      issue(enc_i(12'h010, 5'd0, 3'b010, 5'd20, OPC_LOAD));    // lw x20
      issue(enc_r(7'h00, 5'd0, 5'd20, 3'b000, 5'd21));
      idle(6);
      check_xlen("decodes during pending load", decode_count - start, 1);
      load_return(t, d, 1'b0);
      wait_decodes(start + 2);
      check_xlen("dec_rs1_data", last_rs1, d);
      issue(enc_i(12'h014, 5'd0, 3'b010, 5'd20, OPC_LOAD));
      issue(enc_r(7'h00, 5'd0, 5'd20, 3'b000, 5'd22));
      idle(4);
      load_return(t, ~d, 1'b1);                        // bus error
      wait_decodes(start + 4);
      check_xlen("dec_rs1_data", last_rs1, d);
   endtask

   task automatic test_tag_exhaust();
      int start;
      start = decode_count;
      for (int i = 0; i < NB_DEPTH; i++) begin
         issue(enc_i(12'h020, 5'd0, 3'b010, reg_addr_t'(24 + i), OPC_LOAD));
      end
      issue(enc_i(12'h030, 5'd0, 3'b010, 5'd28, OPC_LOAD));    // no tag left
      idle(3);
      @(negedge clk);
      check_bit("ib_ready", ib_ready, 1'b0);
      check_xlen("decodes with tags exhausted", decode_count - start, NB_DEPTH);
      idle(1);
      load_return(2'd2, lcg_next(), 1'b0);
      wait_decodes(start + NB_DEPTH + 1);
      for (int i = 0; i < NB_DEPTH; i++) begin
         load_return(nb_tag_t'(i), lcg_next(), 1'b0);
      end
   endtask

   task automatic test_illegal();
      int start, n;
      start = decode_count;
      n = illegal_count;
      issue(32'h00208463);                             // beq x1, x2, 8
      idle(6);
      check_xlen("dec_illegal_d cycles", illegal_count - n, 1);
      check_xlen("decodes of illegal", decode_count - start, 0);
   endtask

   initial begin
      arst_n = 1'b0;
      ifu_i0_valid = 1'b0;
      ifu_i0_instr = '0;
      ifu_i0_pc = '0;
      exu_i0_result_x = '0;
      lsu_nb_valid = 1'b0;
      lsu_nb_error = 1'b0;
      lsu_nb_tag = '0;
      lsu_nb_data = '0;
      for (int i = 0; i < 32; i++) shadow[i] = '0;
      for (int i = 0; i < NB_DEPTH; i++) tag_busy[i] = 1'b0;
      repeat (4) @(posedge clk);
      #10;
      arst_n = 1'b1;
      test_reset_state();
      test_decode_fields();
      test_writeback();
      test_raw();
      test_nb_load();
      test_tag_exhaust();
      test_illegal();
      idle(5);
      check_xlen("trace records missing", trace_q.size(), 0);
      if (error_count == 0) begin
         $display("Finished with no errors");
         $finish;
      end else begin
         $display("Finished with errors");
         $fatal(1, "run failed");
      end
   end

endmodule

//--- project.f
+incdir+.
dec_pkg.sv
dec_if.sv
dec_ib.sv
dec_decode.sv
dec_nbload_sb.sv
dec_gpr.sv
dec_result.sv
dec_top.sv
tb_dec.sv
